// ==== source/csi2_defines.svh ====
/*
 * CSI-2 receiver constants
 * lane count, packet data type codes and output FIFO size
 */
`ifndef CSI2_DEFINES_SVH
`define CSI2_DEFINES_SVH

// D-PHY byte lanes, merger ordering assumes two
`define CSI2_LANES 2

// data type codes
`define CSI2_DT_RAW10       6'h2b
`define CSI2_DT_FRAME_START 6'h00
`define CSI2_DT_FRAME_END   6'h01

// output FIFO holds 2**N pixels
`define CSI2_FIFO_ADDR_W 4

`endif

// ==== source/csi2_stream_pkg.sv ====
/*
 * CSI-2 stream types
 * beats on the PHY side, the byte stream and the pixel stream
 */
`include "csi2_defines.svh"

package csi2_stream_pkg;

    typedef logic [7:0] byte_t;
    typedef logic [9:0] pixel_t;

    // one beat from the PHY, lane 0 in the low byte
    typedef struct packed {
        byte_t [`CSI2_LANES-1:0] data;
        logic                    valid;
        logic [`CSI2_LANES-1:0]  active;
    } lane_beat_t;

    typedef struct packed {
        byte_t data;
        logic  last;
        logic  valid;
    } byte_beat_t;

    typedef struct packed {
        pixel_t data;
        logic   user;
        logic   last;
    } pixel_beat_t;

endpackage

// ==== source/csi2_packet_pkg.sv ====
/*
 * CSI-2 packet layer types
 * header fields, parser states and the receiver status pulses
 */
package csi2_packet_pkg;

    typedef logic [5:0]  data_type_t;
    typedef logic [15:0] word_count_t;
    typedef logic [15:0] crc_t;

    typedef enum logic [1:0] {
        st_header,
        st_payload,
        st_crc,
        st_skip
    } parser_state_t;

    // all fields are single-cycle pulses
    typedef struct packed {
        logic ecc_valid;
        logic ecc_corrected;
        logic ecc_error;
        logic crc_valid;
        logic crc_error;
        logic packet_lost;
        logic fifo_overflow;
    } rx_status_t;

endpackage

// ==== source/csi2_lane_merge.sv ====
/*
 * CSI-2 lane merger
 * serialises each two-lane PHY beat into bytes, lane 0 first, and
 * flags the last byte of a burst once active has dropped
 */
`timescale 1ns/10ps
`include "csi2_defines.svh"

module csi2_lane_merge
    import csi2_stream_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  lane_beat_t lane_in,
    output byte_beat_t byte_out
);

    byte_t [`CSI2_LANES-1:0] hold;
    logic                    beat_held;
    logic                    phase;
    logic                    burst_end;

    assign burst_end = !(|lane_in.active);

    always_ff @(posedge aclk) begin
        if (lane_in.valid) begin
            hold <= lane_in.data;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            beat_held <= 1'b0;
            phase     <= 1'b0;
            byte_out  <= '0;
        end else begin
            byte_out.valid <= 1'b0;
            byte_out.last  <= 1'b0;
            if (beat_held) begin
                byte_out.data  <= hold[0];
                byte_out.valid <= 1'b1;
                beat_held      <= 1'b0;
                phase          <= 1'b1;
            end else if (phase && (lane_in.valid || burst_end)) begin
                // lane 1 waits until we know whether the burst goes on
                byte_out.data  <= hold[1];
                byte_out.valid <= 1'b1;
                byte_out.last  <= !lane_in.valid;
                phase          <= 1'b0;
            end
            if (lane_in.valid) begin
                beat_held <= 1'b1;
            end
        end
    end

endmodule

// ==== source/csi2_packet_parser.sv ====
/*
 * CSI-2 packet parser
 * header ECC check and correction, frame start/end decode, RAW10 payload
 * forwarding with CRC-16 check, and detection of truncated bursts
 */
`timescale 1ns/10ps
`include "csi2_defines.svh"

module csi2_packet_parser
    import csi2_stream_pkg::*, csi2_packet_pkg::*;
(
    input  logic       aclk,
    input  logic       aresetn,
    input  byte_beat_t byte_in,
    output byte_beat_t payload,
    output logic       frame_start,
    output logic       frame_end,
    output logic       ecc_valid,
    output logic       ecc_corrected,
    output logic       ecc_error,
    output logic       crc_valid,
    output logic       crc_error,
    output logic       packet_lost
);

    // syndrome of each header data bit, P5 in the msb
    localparam logic [5:0] ECC_COL [24] = '{
        6'h07, 6'h0b, 6'h0d, 6'h0e, 6'h13, 6'h15, 6'h16, 6'h19,
        6'h1a, 6'h1c, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2a, 6'h2c,
        6'h31, 6'h32, 6'h34, 6'h38, 6'h1f, 6'h2f, 6'h37, 6'h3b
    };

    parser_state_t state;
    logic [1:0]    hdr_cnt;
    logic [23:0]   hdr;
    word_count_t   wc_left;
    crc_t          crc;
    byte_t         crc_lo;
    logic          crc_half;

    logic [5:0]    syndrome;
    logic [23:0]   hdr_fix;
    logic          hdr_single;
    logic          hdr_double;
    data_type_t    hdr_dt;
    word_count_t   hdr_wc;

    function automatic logic [5:0] ecc_calc(input logic [23:0] d);
        logic [5:0] p;
        p = '0;
        for (int i = 0; i < 24; i++) begin
            if (d[i]) begin
                p = p ^ ECC_COL[i];
            end
        end
        return p;
    endfunction

    // reflected CCITT, lsb first
    function automatic crc_t crc_next(input crc_t c, input byte_t d);
        crc_t r;
        r = c;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ d[i]) begin
                r = (r >> 1) ^ 16'h8408;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    // ------------------------------
    // header correction, valid while the ECC byte is on the input
    always_comb begin
        syndrome   = ecc_calc(hdr) ^ byte_in.data[5:0];
        hdr_fix    = hdr;
        hdr_single = $onehot(syndrome);
        for (int i = 0; i < 24; i++) begin
            if (syndrome == ECC_COL[i]) begin
                hdr_fix[i] = ~hdr[i];
                hdr_single = 1'b1;
            end
        end
        hdr_double = (syndrome != 6'd0) && !hdr_single;
        hdr_dt     = hdr_fix[5:0];
        hdr_wc     = hdr_fix[23:8];
    end

    always_ff @(posedge aclk) begin
        if (byte_in.valid && state == st_header && hdr_cnt != 2'd3) begin
            hdr[{hdr_cnt, 3'b000} +: 8] <= byte_in.data;
        end
    end

    // ------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state         <= st_header;
            hdr_cnt       <= '0;
            wc_left       <= '0;
            crc           <= '1;
            crc_lo        <= '0;
            crc_half      <= 1'b0;
            payload       <= '0;
            frame_start   <= 1'b0;
            frame_end     <= 1'b0;
            ecc_valid     <= 1'b0;
            ecc_corrected <= 1'b0;
            ecc_error     <= 1'b0;
            crc_valid     <= 1'b0;
            crc_error     <= 1'b0;
            packet_lost   <= 1'b0;
        end else begin
            payload.valid <= 1'b0;
            payload.last  <= 1'b0;
            frame_start   <= 1'b0;
            frame_end     <= 1'b0;
            ecc_valid     <= 1'b0;
            ecc_corrected <= 1'b0;
            ecc_error     <= 1'b0;
            crc_valid     <= 1'b0;
            crc_error     <= 1'b0;
            packet_lost   <= 1'b0;
            if (byte_in.valid) begin
                case (state)
                    st_header: begin
                        hdr_cnt <= hdr_cnt + 2'd1;
                        if (hdr_cnt != 2'd3) begin
                            if (byte_in.last) begin
                                packet_lost <= 1'b1;
                                hdr_cnt     <= '0;
                            end
                        end else begin
                            ecc_valid     <= 1'b1;
                            ecc_corrected <= hdr_single;
                            ecc_error     <= hdr_double;
                            crc           <= '1;
                            crc_half      <= 1'b0;
                            wc_left       <= hdr_wc;
                            state         <= byte_in.last ? st_header : st_skip;
                            if (!hdr_double && hdr_dt < 6'h10) begin
                                frame_start <= (hdr_dt == `CSI2_DT_FRAME_START);
                                frame_end   <= (hdr_dt == `CSI2_DT_FRAME_END);
                            end else if (!hdr_double && hdr_dt == `CSI2_DT_RAW10) begin
                                if (byte_in.last) begin
                                    packet_lost <= 1'b1;
                                end else if (hdr_wc == 16'd0) begin
                                    state <= st_crc;
                                end else begin
                                    state <= st_payload;
                                end
                            end
                        end
                    end
                    st_payload: begin
                        payload.data  <= byte_in.data;
                        payload.valid <= 1'b1;
                        payload.last  <= byte_in.last || (wc_left == 16'd1);
                        crc           <= crc_next(crc, byte_in.data);
                        wc_left       <= wc_left - 16'd1;
                        if (byte_in.last) begin
                            packet_lost <= 1'b1;
                            state       <= st_header;
                        end else if (wc_left == 16'd1) begin
                            state <= st_crc;
                        end
                    end
                    st_crc: begin
                        crc_half <= ~crc_half;
                        if (!crc_half) begin
                            crc_lo <= byte_in.data;
                            if (byte_in.last) begin
                                packet_lost <= 1'b1;
                                state       <= st_header;
                            end
                        end else begin
                            crc_valid <= 1'b1;
                            crc_error <= ({byte_in.data, crc_lo} != crc);
                            state     <= byte_in.last ? st_header : st_skip;
                        end
                    end
                    default: begin
                        // drop until the burst ends
                        if (byte_in.last) begin
                            state <= st_header;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// ==== source/csi2_raw10_unpack.sv ====
/*
 * RAW10 unpacker
 * five payload bytes give four 10-bit pixels, the fifth byte holding
 * the two low bits of each; one group drains while the next gathers
 */
`timescale 1ns/10ps

module csi2_raw10_unpack
    import csi2_stream_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  byte_beat_t  payload,
    output pixel_beat_t pixel_out,
    output logic        pixel_valid
);

    byte_t [3:0] gather;
    logic [2:0]  gather_cnt;
    logic        group_done;
    byte_t [3:0] drain;
    byte_t       drain_lsb;
    logic        drain_last;
    logic [1:0]  drain_idx;
    logic        drain_busy;

    assign group_done = payload.valid && (gather_cnt == 3'd4);

    // ------------------------------
    // gather side
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            gather_cnt <= '0;
        end else if (payload.valid) begin
            // a short group at the end of a line is dropped
            if (gather_cnt == 3'd4 || payload.last) begin
                gather_cnt <= '0;
            end else begin
                gather_cnt <= gather_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (payload.valid && gather_cnt != 3'd4) begin
            gather[gather_cnt[1:0]] <= payload.data;
        end
        if (group_done) begin
            drain      <= gather;
            drain_lsb  <= payload.data;
            drain_last <= payload.last;
        end
    end

    // ------------------------------
    // drain side
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            drain_busy <= 1'b0;
            drain_idx  <= '0;
        end else if (group_done) begin
            drain_busy <= 1'b1;
            drain_idx  <= '0;
        end else if (drain_busy) begin
            drain_idx <= drain_idx + 2'd1;
            if (drain_idx == 2'd3) begin
                drain_busy <= 1'b0;
            end
        end
    end

    assign pixel_valid    = drain_busy;
    assign pixel_out.data = {drain[drain_idx], drain_lsb[{drain_idx, 1'b0} +: 2]};
    assign pixel_out.user = 1'b0;
    assign pixel_out.last = drain_last && (drain_idx == 2'd3);

endmodule

// ==== source/csi2_stream_fifo.sv ====
/*
 * pixel output FIFO
 * single clock, first word fall through; writes into a full FIFO are
 * dropped and reported on overflow
 */
`timescale 1ns/10ps
`include "csi2_defines.svh"

module csi2_stream_fifo
    import csi2_stream_pkg::*;
#(
    parameter int ADDR_W = `CSI2_FIFO_ADDR_W
) (
    input  logic        aclk,
    input  logic        aresetn,
    input  pixel_beat_t s_pixel,
    input  logic        s_valid,
    input  logic        m_ready,
    output pixel_beat_t m_pixel,
    output logic        m_valid,
    output logic        overflow
);

    localparam int DEPTH = 2 ** ADDR_W;

    pixel_beat_t     mem [DEPTH];
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic            full;
    logic            wr_en;
    logic            rd_en;

    // extra pointer bit tells full from empty
    assign full    = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                     (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign m_valid = (wr_ptr != rd_ptr);
    assign wr_en   = s_valid && !full;
    assign rd_en   = m_valid && m_ready;
    assign m_pixel = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= s_pixel;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            overflow <= s_valid && full;
        end
    end

endmodule

// ==== source/csi2_rx.sv ====
/*
 * CSI-2 RAW10 receiver top
 * lane merge, packet parse, RAW10 unpack and output FIFO; tuser marks
 * the first pixel after a frame start or frame end
 */
`timescale 1ns/10ps
`include "csi2_defines.svh"

module csi2_rx
    import csi2_stream_pkg::*, csi2_packet_pkg::*;
(
    input  logic        aclk,
    input  logic        aresetn,
    input  lane_beat_t  lane_in,
    input  logic        m_ready,
    output pixel_beat_t m_pixel,
    output logic        m_valid,
    output rx_status_t  status
);

    byte_beat_t  merged;
    byte_beat_t  payload;
    logic        frame_start;
    logic        frame_end;
    logic        ecc_valid;
    logic        ecc_corrected;
    logic        ecc_error;
    logic        crc_valid;
    logic        crc_error;
    logic        packet_lost;
    pixel_beat_t unpacked;
    logic        unpacked_valid;
    pixel_beat_t fifo_in;
    logic        fifo_overflow;
    logic        frame_flag;

    csi2_lane_merge i_lane_merge (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .lane_in  (lane_in),
        .byte_out (merged)
    );

    csi2_packet_parser i_packet_parser (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .byte_in       (merged),
        .payload       (payload),
        .frame_start   (frame_start),
        .frame_end     (frame_end),
        .ecc_valid     (ecc_valid),
        .ecc_corrected (ecc_corrected),
        .ecc_error     (ecc_error),
        .crc_valid     (crc_valid),
        .crc_error     (crc_error),
        .packet_lost   (packet_lost)
    );

    csi2_raw10_unpack i_raw10_unpack (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .payload     (payload),
        .pixel_out   (unpacked),
        .pixel_valid (unpacked_valid)
    );

    // ------------------------------
    // frame flag, taken by the next pixel out of the unpacker
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            frame_flag <= 1'b0;
        end else if (frame_start || frame_end) begin
            frame_flag <= 1'b1;
        end else if (unpacked_valid) begin
            frame_flag <= 1'b0;
        end
    end

    always_comb begin
        fifo_in      = unpacked;
        fifo_in.user = unpacked.user | frame_flag;
    end

    csi2_stream_fifo #(
        .ADDR_W (`CSI2_FIFO_ADDR_W)
    ) i_stream_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .s_pixel  (fifo_in),
        .s_valid  (unpacked_valid),
        .m_ready  (m_ready),
        .m_pixel  (m_pixel),
        .m_valid  (m_valid),
        .overflow (fifo_overflow)
    );

    assign status = '{
        ecc_valid:     ecc_valid,
        ecc_corrected: ecc_corrected,
        ecc_error:     ecc_error,
        crc_valid:     crc_valid,
        crc_error:     crc_error,
        packet_lost:   packet_lost,
        fifo_overflow: fifo_overflow
    };

endmodule

// ==== tb/csi2_rx_asserts.sv ====
/*
 * CSI-2 receiver assertions
 * PHY input rate, output stability under stall, ECC status exclusivity
 */
`timescale 1ns/10ps

module csi2_rx_asserts
    import csi2_stream_pkg::*, csi2_packet_pkg::*;
(
    input logic        aclk,
    input logic        aresetn,
    input lane_beat_t  lane_in,
    input logic        m_ready,
    input pixel_beat_t m_pixel,
    input logic        m_valid,
    input rx_status_t  status
);

    // one lane beat at most every second cycle
    assert property (@(posedge aclk) disable iff (!aresetn)
        lane_in.valid |=> !lane_in.valid)
        else $error("lane_in.valid high on two cycles in a row");

    assert property (@(posedge aclk) disable iff (!aresetn)
        (m_valid && !m_ready) |=> $stable(m_pixel))
        else $error("m_pixel changed while stalled");

    assert property (@(posedge aclk) disable iff (!aresetn)
        !(status.ecc_corrected && status.ecc_error))
        else $error("ecc_corrected and ecc_error high together");

endmodule

bind csi2_rx csi2_rx_asserts i_csi2_rx_asserts (
    .aclk    (aclk),
    .aresetn (aresetn),
    .lane_in (lane_in),
    .m_ready (m_ready),
    .m_pixel (m_pixel),
    .m_valid (m_valid),
    .status  (status)
);

// ==== tb/csi2_rx_tb.sv ====
/*
 * CSI-2 receiver testbench
 * drives packets from a table as the PHY, models the expected pixels
 * and status pulses, and checks the DUT output stream against them
 */
`timescale 1ns/10ps

module csi2_rx_tb
    import csi2_stream_pkg::*, csi2_packet_pkg::*;
;

    localparam int K_FS    = 0;
    localparam int K_FE    = 1;
    localparam int K_LINE  = 2;
    localparam int K_OTHER = 3;
    localparam int N_TESTS = 12;

    typedef struct packed {
        logic [1:0]  kind;
        logic [15:0] wc;
        logic [1:0]  flip;
        logic        crc_bad;
        logic [15:0] trunc;
        logic        hold;
    } entry_t;

    logic        aclk;
    logic        aresetn;
    lane_beat_t  lane_in;
    logic        m_ready;
    pixel_beat_t m_pixel;
    logic        m_valid;
    rx_status_t  status;

    entry_t      tests [N_TESTS];
    byte_t       pkt_q [$];
    byte_t       pay_q [$];
    pixel_beat_t exp_q [$];
    int          seed;
    int          errors;
    int          checks;
    int          cycles;
    int          limit;
    int          pulse_cnt [7];
    logic        user_pending;

    csi2_rx i_csi2_rx (
        .aclk    (aclk),
        .aresetn (aresetn),
        .lane_in (lane_in),
        .m_ready (m_ready),
        .m_pixel (m_pixel),
        .m_valid (m_valid),
        .status  (status)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // ------------------------------
    // CSI-2 header parity equations
    function automatic logic [5:0] header_ecc(input logic [23:0] d);
        logic [5:0] p;
        p[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
        p[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
        p[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
        p[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
        p[4] = d[4]^d[5]^d[6]^d[7]^d[8]^d[9]^d[16]^d[17]^d[18]^d[19]^d[20]^d[22]^d[23];
        p[5] = d[10]^d[11]^d[12]^d[13]^d[14]^d[15]^d[16]^d[17]^d[18]^d[19]^d[21]^d[22]^d[23];
        return p;
    endfunction

    // CRC-16 CCITT, reflected form, one bit at a time
    function automatic logic [15:0] crc16_update(input logic [15:0] c, input byte_t d);
        logic [15:0] r;
        logic        fb;
        r = c;
        for (int i = 0; i < 8; i++) begin
            fb = r[0] ^ d[i];
            r  = {1'b0, r[15:1]};
            if (fb) begin
                r = r ^ 16'h8408;
            end
        end
        return r;
    endfunction

    function automatic int packet_bytes(input entry_t e);
        if (e.kind == K_FS || e.kind == K_FE) begin
            return 4;
        end
        return 6 + int'(e.wc);
    endfunction

    task automatic build_packet(input entry_t e);
        logic [23:0] hdr;
        logic [5:0]  dt;
        logic [5:0]  ecc;
        logic [15:0] crc;
        byte_t       b;
        int          nsend;
        pkt_q.delete();
        pay_q.delete();
        case (e.kind)
            K_FS:    dt = 6'h00;
            K_FE:    dt = 6'h01;
            K_LINE:  dt = 6'h2b;
            default: dt = 6'h2a;
        endcase
        hdr = {e.wc, 2'b00, dt};
        ecc = header_ecc(hdr);
        if (e.flip == 2'd1) begin
            hdr[0] = ~hdr[0];
        end else if (e.flip == 2'd2) begin
            hdr[1:0] = ~hdr[1:0];
        end
        pkt_q.push_back(hdr[7:0]);
        pkt_q.push_back(hdr[15:8]);
        pkt_q.push_back(hdr[23:16]);
        pkt_q.push_back({2'b00, ecc});
        if (e.kind == K_LINE || e.kind == K_OTHER) begin
            crc = 16'hffff;
            for (int i = 0; i < int'(e.wc); i++) begin
                b = byte_t'($random(seed));
                pay_q.push_back(b);
                crc = crc16_update(crc, b);
            end
            if (e.crc_bad) begin
                crc[0] = ~crc[0];
            end
            nsend = (e.trunc != 16'd0) ? int'(e.trunc) : int'(e.wc);
            for (int i = 0; i < nsend; i++) begin
                pkt_q.push_back(pay_q[i]);
            end
            if (e.trunc == 16'd0) begin
                pkt_q.push_back(crc[7:0]);
                pkt_q.push_back(crc[15:8]);
            end
        end
    endtask

    // four pixels per five bytes, last on the group closing the burst
    task automatic expect_pixels(input entry_t e, output int npix);
        pixel_beat_t px;
        int          nsent;
        npix = 0;
        if (e.kind == K_FS || e.kind == K_FE) begin
            if (e.flip != 2'd2) begin
                user_pending = 1'b1;
            end
            return;
        end
        if (e.kind != K_LINE || e.flip == 2'd2) begin
            return;
        end
        nsent = (e.trunc != 16'd0) ? int'(e.trunc) : int'(e.wc);
        for (int g = 0; 5 * g + 4 < nsent; g++) begin
            for (int k = 0; k < 4; k++) begin
                px.data = {pay_q[5*g+k], pay_q[5*g+4][2*k +: 2]};
                px.last = (k == 3) && (5 * g + 4 == nsent - 1);
                px.user = user_pending;
                user_pending = 1'b0;
                if (npix < 16 || !e.hold) begin
                    exp_q.push_back(px);
                end
                npix++;
            end
        end
    endtask

    task automatic send_packet();
        for (int i = 0; i < pkt_q.size(); i += 2) begin
            @(posedge aclk);
            lane_in <= '{data: {pkt_q[i+1], pkt_q[i]}, valid: 1'b1, active: 2'b11};
            @(posedge aclk);
            lane_in.valid <= 1'b0;
        end
        @(posedge aclk);
        lane_in <= '0;
        repeat (3) @(posedge aclk);
    endtask

    // ------------------------------
    // output monitor
    always @(posedge aclk) begin
        if (aresetn) begin
            for (int i = 0; i < 7; i++) begin
                if (status[i]) begin
                    pulse_cnt[i]++;
                end
            end
            if (m_valid && m_ready) begin
                checks++;
                assert (exp_q.size() != 0) else begin
                    $display("pixel %h came out with none expected", m_pixel);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    assert (m_pixel == exp_q[0]) else begin
                        $display("CHECK FAILED m_pixel got %h expected %h", m_pixel, exp_q[0]);
                        errors++;
                    end
                    void'(exp_q.pop_front());
                end
            end
        end
    end

    always @(posedge aclk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ------------------------------
    initial begin
        int     start_cnt [7];
        int     want [7];
        int     npix;
        int     test_err;
        string  names [7];
        entry_t e;
        names = '{"fifo_overflow", "packet_lost", "crc_error", "crc_valid",
                  "ecc_error", "ecc_corrected", "ecc_valid"};
        aresetn      = 1'b0;
        lane_in      = '0;
        m_ready      = 1'b1;
        seed         = 32'h75166d15;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        user_pending = 1'b0;
        for (int i = 0; i < 7; i++) begin
            pulse_cnt[i] = 0;
        end
        // kind, wc, flip, crc_bad, trunc, hold
        tests = '{
            '{2'd0, 16'd0,  2'd0, 1'b0, 16'd0, 1'b0},
            '{2'd2, 16'd10, 2'd0, 1'b0, 16'd0, 1'b0},
            '{2'd2, 16'd20, 2'd0, 1'b0, 16'd0, 1'b0},
            '{2'd2, 16'd10, 2'd1, 1'b0, 16'd0, 1'b0},
            '{2'd2, 16'd10, 2'd2, 1'b0, 16'd0, 1'b0},
            '{2'd2, 16'd20, 2'd0, 1'b1, 16'd0, 1'b0},
            '{2'd2, 16'd20, 2'd0, 1'b0, 16'd8, 1'b0},
            '{2'd2, 16'd10, 2'd0, 1'b0, 16'd0, 1'b0},
            '{2'd3, 16'd10, 2'd0, 1'b0, 16'd0, 1'b0},
            '{2'd1, 16'd0,  2'd0, 1'b0, 16'd0, 1'b0},
            '{2'd2, 16'd10, 2'd0, 1'b0, 16'd0, 1'b0},
            '{2'd2, 16'd40, 2'd0, 1'b0, 16'd0, 1'b1}
        };
        limit = 200;
        for (int t = 0; t < N_TESTS; t++) begin
            // two bytes every second cycle, so one cycle per byte
            limit += 2 * packet_bytes(tests[t]);
        end
        repeat (3) @(posedge aclk);
        aresetn <= 1'b1;

        for (int t = 0; t < N_TESTS; t++) begin
            e = tests[t];
            @(negedge aclk);
            test_err  = errors;
            start_cnt = pulse_cnt;
            build_packet(e);
            expect_pixels(e, npix);
            want[6] = 1;
            want[5] = (e.flip == 2'd1) ? 1 : 0;
            want[4] = (e.flip == 2'd2) ? 1 : 0;
            want[3] = (e.kind == K_LINE && e.flip != 2'd2 && e.trunc == 16'd0) ? 1 : 0;
            want[2] = (want[3] == 1 && e.crc_bad) ? 1 : 0;
            want[1] = (e.kind == K_LINE && e.flip != 2'd2 && e.trunc != 16'd0) ? 1 : 0;
            want[0] = (e.hold && npix > 16) ? npix - 16 : 0;
            if (e.hold) begin
                @(posedge aclk);
                m_ready <= 1'b0;
            end
            send_packet();
            if (e.hold) begin
                repeat (16) @(posedge aclk);
                m_ready <= 1'b1;
            end
            while (exp_q.size() != 0) begin
                @(negedge aclk);
            end
            repeat (12) @(negedge aclk);
            for (int i = 0; i < 7; i++) begin
                checks++;
                assert (pulse_cnt[i] - start_cnt[i] == want[i]) else begin
                    $display("CHECK FAILED %s count got %h expected %h", names[i],
                             pulse_cnt[i] - start_cnt[i], want[i]);
                    errors++;
                end
            end
            $display("test %0d kind %0d wc %0d pixels %0d: %s", t, e.kind, e.wc, npix,
                     (errors == test_err) ? "ok" : "errors");
        end

        $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+source
source/csi2_stream_pkg.sv
source/csi2_packet_pkg.sv
source/csi2_lane_merge.sv
source/csi2_packet_parser.sv
source/csi2_raw10_unpack.sv
source/csi2_stream_fifo.sv
source/csi2_rx.sv
tb/csi2_rx_asserts.sv
tb/csi2_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the CSI-2 receiver testbench with Verilator
verilator --binary --timing --assert --top-module csi2_rx_tb -f list.f \
    -o csi2_rx_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/csi2_rx_sim > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log && ! grep -q "CHECKS FAILED" sim.log && {
    echo "simulation passed"; exit 0; } || {
    echo "simulation failed, see sim.log"; exit 1; }
